//--- Makefile
# Verilator build and run of the status memory testbench

VERILATOR ?= verilator
TOP       ?= tb_status_mem
FILELIST  ?= status_mem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
RUN_ARGS  ?=

SOURCES := $(shell cat $(FILELIST)) testbench/status_mem_patterns.hex

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- src/neuro_status_pkg.sv
// **********************************************************************
// Shared definitions for the neuron status memory.
// Holds the state field code and the default widths that the top level
// uses for its parameters. Referenced by scoped names only.
// **********************************************************************

`default_nettype none

package neuro_status_pkg;

	// state field code, same order as the port A field select
	typedef enum logic [1:0] {
		FIELD_BIAS      = 2'b00,
		FIELD_POTENTIAL = 2'b01,
		FIELD_THRESHOLD = 2'b10,
		FIELD_POST_HIST = 2'b11
	} state_field_e;

	// neuron index width
	localparam int DEF_NEURON_AW = 8;

	// axon index width, appended below the neuron index for synapse addresses
	localparam int DEF_AXON_AW = 8;

	// bias, potential, threshold and weight words
	localparam int DEF_WORD_W = 16;

	// spike history (STDP window) value
	localparam int DEF_HIST_W = 8;

	// weight fifo depth is 2**DEF_FIFO_AW
	localparam int DEF_FIFO_AW = 9;

endpackage

`default_nettype wire

//--- src/state_field_ctrl.sv
// **********************************************************************
// State field controller of the neuron status memory.
// Turns the port A and port B field codes into one-hot RAM enables,
// keeps the field select of the last port A read for the output mux and
// delays each weight read by one cycle into the weight FIFO push.
// **********************************************************************

`default_nettype none

module state_field_ctrl #(
	parameter int WORD_W = neuro_status_pkg::DEF_WORD_W
) (
	input  wire logic                          clk_i,
	input  wire logic                          rst_n_i,
	input  wire logic                          state_rd_en_i,
	input  wire neuro_status_pkg::state_field_e state_rd_field_i,
	input  wire logic                          state_wr_en_i,
	input  wire neuro_status_pkg::state_field_e state_wr_field_i,
	input  wire logic [WORD_W-1:0]             bias_data_i,
	input  wire logic [WORD_W-1:0]             potential_data_i,
	input  wire logic [WORD_W-1:0]             threshold_data_i,
	input  wire logic [WORD_W-1:0]             post_hist_data_i,
	input  wire logic                          weight_rd_en_i,
	output      logic [3:0]                    field_rd_en_o,
	output      logic [3:0]                    field_wr_en_o,
	output      logic [WORD_W-1:0]             state_rd_data_o,
	output      logic                          fifo_push_o
);

	neuro_status_pkg::state_field_e field_sel_q;
	logic                           write_pending;

	// one-hot enables, bit index equals the field code
	assign field_rd_en_o = state_rd_en_i ? (4'b0001 << state_rd_field_i) : 4'b0000;
	assign field_wr_en_o = state_wr_en_i ? (4'b0001 << state_wr_field_i) : 4'b0000;

	// select only moves on a port A read so the output stays put
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			field_sel_q <= neuro_status_pkg::FIELD_BIAS;
		end
		else if (state_rd_en_i)
		begin
			field_sel_q <= state_rd_field_i;
		end
	end

	always_comb
	begin
		case (field_sel_q)
			neuro_status_pkg::FIELD_BIAS:      state_rd_data_o = bias_data_i;
			neuro_status_pkg::FIELD_POTENTIAL: state_rd_data_o = potential_data_i;
			neuro_status_pkg::FIELD_THRESHOLD: state_rd_data_o = threshold_data_i;
			default:                           state_rd_data_o = post_hist_data_i;
		endcase
	end

	// weight word is valid one cycle after its read enable
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			write_pending <= 1'b0;
		end
		else
		begin
			write_pending <= weight_rd_en_i;
		end
	end

	assign fifo_push_o = write_pending;

endmodule

`default_nettype wire

//--- src/status_mem.sv
// **********************************************************************
// On-chip status memory of one neuron core.
// Port A/B access the four per-neuron state fields, ports C/D the
// pre-spike history and ports G/E the weights. Every weight read on
// port E is queued for the learning engine, which drains it on port F.
// **********************************************************************

`default_nettype none

module status_mem #(
	parameter int NEURON_AW = neuro_status_pkg::DEF_NEURON_AW,
	parameter int AXON_AW   = neuro_status_pkg::DEF_AXON_AW,
	parameter int WORD_W    = neuro_status_pkg::DEF_WORD_W,
	parameter int HIST_W    = neuro_status_pkg::DEF_HIST_W,
	parameter int FIFO_AW   = neuro_status_pkg::DEF_FIFO_AW
) (
	input  wire logic                          clk_i,
	input  wire logic                          rst_n_i,
	input  wire logic                          start_i,
	// port A
	input  wire logic                          state_rd_en_i,
	input  wire logic [NEURON_AW-1:0]          state_rd_neuron_i,
	input  wire neuro_status_pkg::state_field_e state_rd_field_i,
	output      logic [WORD_W-1:0]             state_rd_data_o,
	// port B
	input  wire logic                          state_wr_en_i,
	input  wire logic [NEURON_AW-1:0]          state_wr_neuron_i,
	input  wire neuro_status_pkg::state_field_e state_wr_field_i,
	input  wire logic [WORD_W-1:0]             state_wr_data_i,
	// port C
	input  wire logic                          prehist_rd_en_i,
	input  wire logic [NEURON_AW+AXON_AW-1:0]  prehist_rd_addr_i,
	output      logic [HIST_W-1:0]             prehist_rd_data_o,
	// port D
	input  wire logic                          prehist_wr_en_i,
	input  wire logic [NEURON_AW+AXON_AW-1:0]  prehist_wr_addr_i,
	input  wire logic [HIST_W-1:0]             prehist_wr_data_i,
	// port G
	input  wire logic                          weight_wr_en_i,
	input  wire logic [NEURON_AW+AXON_AW-1:0]  weight_wr_addr_i,
	input  wire logic [WORD_W-1:0]             weight_wr_data_i,
	// port E
	input  wire logic                          weight_rd_en_i,
	input  wire logic [NEURON_AW+AXON_AW-1:0]  weight_rd_addr_i,
	output      logic [WORD_W-1:0]             weight_rd_data_o,
	// port F
	input  wire logic                          fifo_rd_en_i,
	output      logic [WORD_W-1:0]             fifo_data_o,
	output      logic                          fifo_empty_o,
	output      logic                          fifo_full_o
);

	localparam int SYN_AW = NEURON_AW + AXON_AW;

	logic [3:0]        field_rd_en;
	logic [3:0]        field_wr_en;
	logic [WORD_W-1:0] field_data [4];
	logic [WORD_W-1:0] post_hist_wr_data;
	logic              fifo_push;

	// post-spike history keeps only its window bits, zero-extended
	assign post_hist_wr_data = WORD_W'(state_wr_data_i[HIST_W-1:0]);

	state_field_ctrl #(
		.WORD_W (WORD_W)
	) state_field_ctrl_i (
		.clk_i            (clk_i),
		.rst_n_i          (rst_n_i),
		.state_rd_en_i    (state_rd_en_i),
		.state_rd_field_i (state_rd_field_i),
		.state_wr_en_i    (state_wr_en_i),
		.state_wr_field_i (state_wr_field_i),
		.bias_data_i      (field_data[neuro_status_pkg::FIELD_BIAS]),
		.potential_data_i (field_data[neuro_status_pkg::FIELD_POTENTIAL]),
		.threshold_data_i (field_data[neuro_status_pkg::FIELD_THRESHOLD]),
		.post_hist_data_i (field_data[neuro_status_pkg::FIELD_POST_HIST]),
		.weight_rd_en_i   (weight_rd_en_i),
		.field_rd_en_o    (field_rd_en),
		.field_wr_en_o    (field_wr_en),
		.state_rd_data_o  (state_rd_data_o),
		.fifo_push_o      (fifo_push)
	);

	// one RAM per state field, index equals the field code
	for (genvar f = 0; f < 4; f++)
	begin : g_field_ram
		status_ram #(
			.AW        (NEURON_AW),
			.payload_t (logic [WORD_W-1:0])
		) field_ram_i (
			.clk_i     (clk_i),
			.wr_en_i   (field_wr_en[f]),
			.wr_addr_i (state_wr_neuron_i),
			.wr_data_i ((f == 3) ? post_hist_wr_data : state_wr_data_i),
			.rd_en_i   (field_rd_en[f]),
			.rd_addr_i (state_rd_neuron_i),
			.rd_data_o (field_data[f])
		);
	end

	status_ram #(
		.AW        (SYN_AW),
		.payload_t (logic [HIST_W-1:0])
	) prehist_ram_i (
		.clk_i     (clk_i),
		.wr_en_i   (prehist_wr_en_i),
		.wr_addr_i (prehist_wr_addr_i),
		.wr_data_i (prehist_wr_data_i),
		.rd_en_i   (prehist_rd_en_i),
		.rd_addr_i (prehist_rd_addr_i),
		.rd_data_o (prehist_rd_data_o)
	);

	status_ram #(
		.AW        (SYN_AW),
		.payload_t (logic [WORD_W-1:0])
	) weight_ram_i (
		.clk_i     (clk_i),
		.wr_en_i   (weight_wr_en_i),
		.wr_addr_i (weight_wr_addr_i),
		.wr_data_i (weight_wr_data_i),
		.rd_en_i   (weight_rd_en_i),
		.rd_addr_i (weight_rd_addr_i),
		.rd_data_o (weight_rd_data_o)
	);

	// push one cycle after the read, once the RAM output has settled
	weight_fifo #(
		.AW    (FIFO_AW),
		.WIDTH (WORD_W)
	) weight_fifo_i (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.clr_i       (start_i),
		.push_i      (fifo_push),
		.push_data_i (weight_rd_data_o),
		.pop_i       (fifo_rd_en_i),
		.pop_data_o  (fifo_data_o),
		.empty_o     (fifo_empty_o),
		.full_o      (fifo_full_o)
	);

endmodule

`default_nettype wire

//--- src/status_ram.sv
// **********************************************************************
// Simple dual-port RAM with a registered read address.
// Write is synchronous; the read address loads on rd_en_i and the output
// follows the memory content at that address until the next read.
// **********************************************************************

`default_nettype none

module status_ram #(
	parameter int  AW        = neuro_status_pkg::DEF_NEURON_AW,
	parameter type payload_t = logic [neuro_status_pkg::DEF_WORD_W-1:0]
) (
	input  wire logic            clk_i,
	input  wire logic            wr_en_i,
	input  wire logic [AW-1:0]   wr_addr_i,
	input  wire payload_t        wr_data_i,
	input  wire logic            rd_en_i,
	input  wire logic [AW-1:0]   rd_addr_i,
	output      payload_t        rd_data_o
);

	payload_t       mem [2**AW];
	logic [AW-1:0]  rd_addr_q;

	always_ff @(posedge clk_i)
	begin
		if (wr_en_i)
		begin
			mem[wr_addr_i] <= wr_data_i;
		end
	end

	// address is held between reads
	always_ff @(posedge clk_i)
	begin
		if (rd_en_i)
		begin
			rd_addr_q <= rd_addr_i;
		end
	end

	// write to the held address shows up right after the write edge
	assign rd_data_o = mem[rd_addr_q];

endmodule

`default_nettype wire

//--- src/weight_fifo.sv
// **********************************************************************
// Show-ahead synchronous FIFO for weight words.
// pop_data_o is the oldest entry while empty_o is low. clr_i empties the
// buffer and overrides a push or pop in the same cycle.
// **********************************************************************

`default_nettype none

module weight_fifo #(
	parameter int AW    = neuro_status_pkg::DEF_FIFO_AW,
	parameter int WIDTH = neuro_status_pkg::DEF_WORD_W
) (
	input  wire logic             clk_i,
	input  wire logic             rst_n_i,
	input  wire logic             clr_i,
	input  wire logic             push_i,
	input  wire logic [WIDTH-1:0] push_data_i,
	input  wire logic             pop_i,
	output      logic [WIDTH-1:0] pop_data_o,
	output      logic             empty_o,
	output      logic             full_o
);

	logic [WIDTH-1:0] mem [2**AW];

	// extra msb tells a full buffer from an empty one
	logic [AW:0] wr_ptr_q;
	logic [AW:0] rd_ptr_q;

	logic push_ok;
	logic pop_ok;

	assign empty_o = (wr_ptr_q == rd_ptr_q);
	assign full_o  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
	                 (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

	// push when full is dropped, pop when empty does nothing
	assign push_ok = push_i && !full_o && !clr_i;
	assign pop_ok  = pop_i && !empty_o && !clr_i;

	always_ff @(posedge clk_i)
	begin
		if (push_ok)
		begin
			mem[wr_ptr_q[AW-1:0]] <= push_data_i;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end
		else if (clr_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end
		else
		begin
			if (push_ok)
			begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop_ok)
			begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
		end
	end

	// head entry, not meaningful while empty
	assign pop_data_o = mem[rd_ptr_q[AW-1:0]];

endmodule

`default_nettype wire

//--- status_mem.f
src/neuro_status_pkg.sv
src/status_ram.sv
src/state_field_ctrl.sv
src/weight_fifo.sv
src/status_mem.sv
testbench/status_mem_assertions.sv
testbench/tb_status_mem.sv

//--- testbench/status_mem_assertions.sv
// **********************************************************************
// Protocol assertions for the status memory, bound into status_mem.
// Checks weight FIFO back-pressure, flag consistency and start clearing.
// **********************************************************************

`default_nettype none

module status_mem_assertions (
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire logic start_i,
	input wire logic weight_rd_en_i,
	input wire logic fifo_empty_i,
	input wire logic fifo_full_i
);
	timeunit 1ns;
	timeprecision 100ps;

	// number of failed properties so far
	int failures = 0;

	// the learning side must drain the FIFO before more weights are read
	read_not_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		weight_rd_en_i |-> !fifo_full_i)
	else
	begin
		failures++;
		$error("weight read issued while the weight FIFO is full");
	end

	flags_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(fifo_empty_i && fifo_full_i))
	else
	begin
		failures++;
		$error("weight FIFO reports empty and full at once");
	end

	start_clears: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		start_i |=> fifo_empty_i)
	else
	begin
		failures++;
		$error("weight FIFO not empty in the cycle after start");
	end

endmodule

bind status_mem status_mem_assertions status_mem_assertions_i (
	.clk_i          (clk_i),
	.rst_n_i        (rst_n_i),
	.start_i        (start_i),
	.weight_rd_en_i (weight_rd_en_i),
	.fifo_empty_i   (fifo_empty_o),
	.fifo_full_i    (fifo_full_o)
);

`default_nettype wire

//--- testbench/status_mem_patterns.hex
// columns op_addr_field_data_expect; op 1 state wr, 2 state rd, 3 prehist wr, 4 prehist rd,
// 5 weight wr, 6 weight rd, 7 fifo pop, 8 fifo flags {empty,full}, 9 start, a held state out
1_03_0_1111_0000
1_03_1_2222_0000
1_03_2_3333_0000
1_03_3_12ab_0000
1_07_0_4444_0000
1_07_3_55cd_0000
2_03_0_0000_1111
2_03_1_0000_2222
2_03_2_0000_3333
2_03_3_0000_00ab
2_07_0_0000_4444
2_07_3_0000_00cd
1_07_0_9999_0000
a_00_0_0000_00cd
1_07_3_0077_0000
a_00_0_0000_0077
3_35_0_00a5_0000
5_35_0_beef_0000
3_36_0_005a_0000
5_36_0_cafe_0000
4_35_0_0000_00a5
6_35_0_0000_beef
6_36_0_0000_cafe
4_36_0_0000_005a
7_00_0_0000_beef
7_00_0_0000_cafe
8_00_0_0000_0002
6_35_0_0000_beef
6_36_0_0000_cafe
6_35_0_0000_beef
6_36_0_0000_cafe
6_35_0_0000_beef
6_36_0_0000_cafe
6_35_0_0000_beef
6_36_0_0000_cafe
8_00_0_0000_0001
9_00_0_0000_0000
8_00_0_0000_0002
6_36_0_0000_cafe
8_00_0_0000_0000
7_00_0_0000_cafe
8_00_0_0000_0002

//--- testbench/tb_status_mem.sv
// **********************************************************************
// Testbench for the status memory. Replays the operation records of
// the pattern file one per clock cycle and checks each read against
// the expected value stored in the record.
// **********************************************************************

`default_nettype none

module tb_status_mem;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NEURON_AW   = 4;
	localparam int AXON_AW     = 4;
	localparam int WORD_W      = 16;
	localparam int HIST_W      = 8;
	localparam int FIFO_AW     = 3;
	localparam int SYN_AW      = NEURON_AW + AXON_AW;
	localparam int MAX_RECORDS = 64;

	// record op codes
	localparam logic [3:0] OP_END        = 4'h0;
	localparam logic [3:0] OP_STATE_WR   = 4'h1;
	localparam logic [3:0] OP_STATE_RD   = 4'h2;
	localparam logic [3:0] OP_PREHIST_WR = 4'h3;
	localparam logic [3:0] OP_PREHIST_RD = 4'h4;
	localparam logic [3:0] OP_WEIGHT_WR  = 4'h5;
	localparam logic [3:0] OP_WEIGHT_RD  = 4'h6;
	localparam logic [3:0] OP_FIFO_POP   = 4'h7;
	localparam logic [3:0] OP_FLAGS      = 4'h8;
	localparam logic [3:0] OP_START      = 4'h9;
	localparam logic [3:0] OP_HELD       = 4'ha;

	logic                           clk_i;
	logic                           rst_n_i;
	logic                           start_i;
	logic                           state_rd_en_i;
	logic [NEURON_AW-1:0]           state_rd_neuron_i;
	neuro_status_pkg::state_field_e state_rd_field_i;
	logic [WORD_W-1:0]              state_rd_data_o;
	logic                           state_wr_en_i;
	logic [NEURON_AW-1:0]           state_wr_neuron_i;
	neuro_status_pkg::state_field_e state_wr_field_i;
	logic [WORD_W-1:0]              state_wr_data_i;
	logic                           prehist_rd_en_i;
	logic [SYN_AW-1:0]              prehist_rd_addr_i;
	logic [HIST_W-1:0]              prehist_rd_data_o;
	logic                           prehist_wr_en_i;
	logic [SYN_AW-1:0]              prehist_wr_addr_i;
	logic [HIST_W-1:0]              prehist_wr_data_i;
	logic                           weight_wr_en_i;
	logic [SYN_AW-1:0]              weight_wr_addr_i;
	logic [WORD_W-1:0]              weight_wr_data_i;
	logic                           weight_rd_en_i;
	logic [SYN_AW-1:0]              weight_rd_addr_i;
	logic [WORD_W-1:0]              weight_rd_data_o;
	logic                           fifo_rd_en_i;
	logic [WORD_W-1:0]              fifo_data_o;
	logic                           fifo_empty_o;
	logic                           fifo_full_o;

	// op, addr, field, data, expected as 1, 2, 1, 4, 4 hex digits
	logic [47:0] patterns [MAX_RECORDS];
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          cycle_limit = 100;

	status_mem #(
		.NEURON_AW (NEURON_AW),
		.AXON_AW   (AXON_AW),
		.WORD_W    (WORD_W),
		.HIST_W    (HIST_W),
		.FIFO_AW   (FIFO_AW)
	) status_mem_i (.*);

	always #4 clk_i = ~clk_i;

	always @(posedge clk_i)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			$display("timeout: pattern run still busy after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic drive_idle();
		start_i           = 1'b0;
		state_rd_en_i     = 1'b0;
		state_rd_neuron_i = '0;
		state_rd_field_i  = neuro_status_pkg::FIELD_BIAS;
		state_wr_en_i     = 1'b0;
		state_wr_neuron_i = '0;
		state_wr_field_i  = neuro_status_pkg::FIELD_BIAS;
		state_wr_data_i   = '0;
		prehist_rd_en_i   = 1'b0;
		prehist_rd_addr_i = '0;
		prehist_wr_en_i   = 1'b0;
		prehist_wr_addr_i = '0;
		prehist_wr_data_i = '0;
		weight_wr_en_i    = 1'b0;
		weight_wr_addr_i  = '0;
		weight_wr_data_i  = '0;
		weight_rd_en_i    = 1'b0;
		weight_rd_addr_i  = '0;
		fifo_rd_en_i      = 1'b0;
	endtask

	task automatic compare_value(input string what, input logic [WORD_W-1:0] got,
			input logic [WORD_W-1:0] expected);
		checks++;
		assert (got === expected)
		else
		begin
			errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	// one record per cycle with read checks just after the strobe edge
	task automatic apply_record(input logic [47:0] rec);
		logic [3:0]        op;
		logic [SYN_AW-1:0] addr;
		logic [1:0]        field;
		logic [WORD_W-1:0] data;
		logic [WORD_W-1:0] expected;
		op       = rec[47:44];
		addr     = rec[43:36];
		field    = rec[33:32];
		data     = rec[31:16];
		expected = rec[15:0];
		case (op)
			OP_STATE_WR:
			begin
				state_wr_en_i     = 1'b1;
				state_wr_neuron_i = addr[NEURON_AW-1:0];
				state_wr_field_i  = neuro_status_pkg::state_field_e'(field);
				state_wr_data_i   = data;
			end
			OP_STATE_RD:
			begin
				state_rd_en_i     = 1'b1;
				state_rd_neuron_i = addr[NEURON_AW-1:0];
				state_rd_field_i  = neuro_status_pkg::state_field_e'(field);
			end
			OP_PREHIST_WR:
			begin
				prehist_wr_en_i   = 1'b1;
				prehist_wr_addr_i = addr;
				prehist_wr_data_i = data[HIST_W-1:0];
			end
			OP_PREHIST_RD:
			begin
				prehist_rd_en_i   = 1'b1;
				prehist_rd_addr_i = addr;
			end
			OP_WEIGHT_WR:
			begin
				weight_wr_en_i   = 1'b1;
				weight_wr_addr_i = addr;
				weight_wr_data_i = data;
			end
			OP_WEIGHT_RD:
			begin
				weight_rd_en_i   = 1'b1;
				weight_rd_addr_i = addr;
			end
			OP_FIFO_POP:
			begin
				// head is checked before it is popped
				compare_value("fifo head", fifo_data_o, expected);
				fifo_rd_en_i = 1'b1;
			end
			OP_START: start_i = 1'b1;
			default: ;
		endcase
		@(posedge clk_i);
		#1;
		drive_idle();
		case (op)
			OP_STATE_RD: compare_value("state field", state_rd_data_o, expected);
			OP_HELD: compare_value("held state field", state_rd_data_o, expected);
			OP_PREHIST_RD: compare_value("pre-history", WORD_W'(prehist_rd_data_o), expected);
			OP_WEIGHT_RD: compare_value("weight", weight_rd_data_o, expected);
			OP_FLAGS: compare_value("fifo {empty,full}",
				{{(WORD_W-2){1'b0}}, fifo_empty_o, fifo_full_o}, expected);
			default: ;
		endcase
	endtask

	initial
	begin
		int n_records;
		int assert_failures;
		clk_i   = 1'b0;
		rst_n_i = 1'b0;
		drive_idle();
		for (int i = 0; i < MAX_RECORDS; i++)
		begin
			patterns[i] = '0;
		end
		$readmemh("testbench/status_mem_patterns.hex", patterns);
		n_records = 0;
		while (n_records < MAX_RECORDS && patterns[n_records][47:44] != OP_END)
		begin
			n_records++;
		end
		cycle_limit = 4 * n_records + 100;
		if (n_records == 0)
		begin
			errors++;
			$display("no operation records were loaded from the pattern file");
		end
		repeat (8) @(posedge clk_i);
		#1;
		rst_n_i = 1'b1;
		for (int i = 0; i < n_records; i++)
		begin
			apply_record(patterns[i]);
		end
		@(posedge clk_i);
		assert_failures = status_mem_i.status_mem_assertions_i.failures;
		$display("records: %0d checks: %0d errors: %0d assertion failures: %0d",
			n_records, checks, errors, assert_failures);
		if (errors == 0 && assert_failures == 0)
		begin
			$display("TEST PASSED");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
